// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module uartTb -f flist.f -o uartTb

run: compile
	@out=$$(./obj_dir/uartTb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: dv/uartTb.sv
`default_nettype none

module uartTb;

	logic clk;
	logic reset;
	uartPkg::uartCmd cmd;
	logic cmdStrobe;
	logic [7:0] wrData;
	uartPkg::uartReadWord rdData;
	logic rdStrobe;
	logic rx;
	logic tx;
	logic loopback;		// routes tx straight back into rx
	logic modelRx;		// rx level from the serial model
	logic readCmd;		// any command that loads rdData
	logic [31:0] lfsr;
	logic [7:0] sent [uartPkg::fifoDepth + 2];	// bytes in the order written or sent
	int errorCount;
	int timeoutCount;

	assign rx = loopback ? tx : modelRx;
	assign readCmd = cmdStrobe && (cmd == uartPkg::cmdRead || cmd == uartPkg::cmdStat);

	uartPeripheral dut0 (
		.clk(clk), .reset(reset),
		.cmd(cmd), .cmdStrobe(cmdStrobe), .wrData(wrData),
		.rdData(rdData), .rdStrobe(rdStrobe),
		.rx(rx), .tx(tx)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// bus timing checks
	////////////////////////////////////////////////////////////////////////////

	strobeFollows: assert property (@(posedge clk) disable iff (reset) readCmd |=> rdStrobe)
	else
	begin
		errorCount++;
		$display("** Error at %0t: rdStrobe missing one cycle after a read", $time);
	end

	strobeOnlyAfterRead: assert property (@(posedge clk) disable iff (reset)
		rdStrobe |-> $past(readCmd))
	else
	begin
		errorCount++;
		$display("** Error at %0t: rdStrobe without a read one cycle before", $time);
	end

	dataHolds: assert property (@(posedge clk) disable iff (reset)
		!readCmd |=> $stable(rdData.data))
	else
	begin
		errorCount++;
		$display("** Error at %0t: rdData changed with no read", $time);
	end

	lineIdleInReset: assert property (@(posedge clk) reset |=> tx)
	else
	begin
		errorCount++;
		$display("** Error at %0t: tx low during reset", $time);
	end

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic drawByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);	// one step per bit
			b[i] = lfsr[0];
		end
	endtask

	// expected status built from the bit layout high to low
	function automatic uartPkg::uartStatus statusOf(input logic ovr, input logic busy,
		input logic rxF, input logic rxE, input logic txF, input logic txE);
		return '{reserved: 2'b00, rxOverrun: ovr, txBusy: busy, rxFull: rxF,
			rxEmpty: rxE, txFull: txF, txEmpty: txE};
	endfunction

	task automatic expectEqual(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic issueCmd(input uartPkg::uartCmd c, input logic [7:0] d);
		@(negedge clk);
		cmd = c;
		wrData = d;
		cmdStrobe = 1'b1;
		@(negedge clk);
		cmdStrobe = 1'b0;	// one cycle strobe
		cmd = uartPkg::cmdNone;
	endtask

	// result is due exactly one cycle after the strobe
	task automatic readResult(input uartPkg::uartCmd c, output logic [7:0] r);
		issueCmd(c, 8'h00);
		expectEqual("rdStrobe after read", {7'b0, rdStrobe}, 8'h01);
		r = rdData.data;
	endtask

	task automatic checkStatus(input string what, input uartPkg::uartStatus exp);
		logic [7:0] got;
		readResult(uartPkg::cmdStat, got);
		expectEqual(what, got, exp);
	endtask

	task automatic checkRead(input string what, input logic [7:0] exp);
		logic [7:0] got;
		readResult(uartPkg::cmdRead, got);
		expectEqual(what, got, exp);
	endtask

	// poll status until the tx fifo is drained and the last frame is out
	task automatic waitTxIdle(input int maxPolls);
		logic [7:0] raw;
		uartPkg::uartStatus s;
		int polls;
		polls = 0;
		s = '0;
		while (!(s.txEmpty && !s.txBusy) && polls < maxPolls)
		begin
			readResult(uartPkg::cmdStat, raw);
			s = uartPkg::uartStatus'(raw);
			polls++;
		end
		if (!(s.txEmpty && !s.txBusy))
		begin
			timeoutCount++;
			$display("Timeout at %0t: the transmitter never went idle", $time);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// serial line model at 64 clk per bit
	////////////////////////////////////////////////////////////////////////////

	task automatic decodeFrame(input string what, input logic [7:0] exp);
		int waitCnt;
		logic [7:0] b;
		b = '0;
		waitCnt = 0;
		while (tx !== 1'b0 && waitCnt < 2000)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (tx !== 1'b0)
		begin
			timeoutCount++;
			$display("Timeout at %0t: no start bit appeared on tx", $time);
			return;
		end
		repeat (uartPkg::overSample * uartPkg::baudDivisor / 2) @(negedge clk);	// mid start
		expectEqual("start bit", {7'b0, tx}, 8'h00);
		for (int i = 0; i < 8; i++)
		begin
			repeat (uartPkg::overSample * uartPkg::baudDivisor) @(negedge clk);
			b[i] = tx;	// lsb first
		end
		repeat (uartPkg::overSample * uartPkg::baudDivisor) @(negedge clk);
		expectEqual("stop bit", {7'b0, tx}, 8'h01);
		expectEqual(what, b, exp);
	endtask

	task automatic sendFrame(input logic [7:0] b);
		@(negedge clk);
		modelRx = 1'b0;
		repeat (uartPkg::overSample * uartPkg::baudDivisor) @(negedge clk);
		for (int i = 0; i < 8; i++)
		begin
			modelRx = b[i];
			repeat (uartPkg::overSample * uartPkg::baudDivisor) @(negedge clk);
		end
		modelRx = 1'b1;	// full stop bit
		repeat (uartPkg::overSample * uartPkg::baudDivisor - 1) @(negedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// behaviors
	////////////////////////////////////////////////////////////////////////////

	task automatic resetChecks();
		for (int k = 0; k < 50; k++)
		begin
			@(negedge clk);
			expectEqual("tx after reset", {7'b0, tx}, 8'h01);
		end
		checkStatus("status after reset", statusOf(0, 0, 0, 1, 0, 1));
	endtask

	task automatic txFrameChecks();
		for (int i = 0; i < 3; i++)
			drawByte(sent[i]);
		fork
			for (int i = 0; i < 3; i++)
				issueCmd(uartPkg::cmdWrite, sent[i]);
			for (int i = 0; i < 3; i++)
				decodeFrame("frame on tx", sent[i]);
		join
	endtask

	task automatic loopbackChecks();
		@(negedge clk);
		loopback = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			drawByte(sent[i]);
			issueCmd(uartPkg::cmdWrite, sent[i]);
		end
		waitTxIdle(2000);
		for (int i = 0; i < 4; i++)
			checkRead("looped byte", sent[i]);
		checkRead("read of empty rx fifo", 8'h00);
		checkStatus("status after loopback", statusOf(0, 0, 0, 1, 0, 1));
	endtask

	// one frame in flight plus a full fifo so the last write is dropped
	task automatic burstChecks();
		for (int i = 0; i < uartPkg::fifoDepth + 2; i++)
			drawByte(sent[i]);
		fork
			begin
				for (int i = 0; i < uartPkg::fifoDepth + 2; i++)
					issueCmd(uartPkg::cmdWrite, sent[i]);
				checkStatus("status after burst", statusOf(0, 1, 0, 1, 1, 0));
			end
			begin
				for (int i = 0; i <= uartPkg::fifoDepth; i++)
				begin
					decodeFrame("burst frame", sent[i]);
					if (i > 0)
						checkRead("burst byte read back", sent[i - 1]);	// one behind
				end
				for (int k = 0; k < 120; k++)
				begin
					@(negedge clk);
					expectEqual("tx after last burst frame", {7'b0, tx}, 8'h01);
				end
			end
		join
		waitTxIdle(500);
		checkRead("last burst byte", sent[uartPkg::fifoDepth]);
		checkRead("read of empty rx fifo", 8'h00);
		@(negedge clk);
		loopback = 1'b0;
	endtask

	task automatic overrunChecks();
		for (int i = 0; i <= uartPkg::fifoDepth; i++)
		begin
			drawByte(sent[i]);
			sendFrame(sent[i]);
		end
		checkStatus("status after overrun", statusOf(1, 0, 1, 0, 0, 1));
		for (int i = 0; i < uartPkg::fifoDepth; i++)
			checkRead("received byte", sent[i]);
		checkStatus("status after draining", statusOf(0, 0, 0, 1, 0, 1));
	endtask

	task automatic glitchChecks();
		@(negedge clk);
		modelRx = 1'b0;
		repeat (16) @(negedge clk);	// well short of mid-bit
		modelRx = 1'b1;
		// a false frame of all ones would have landed in the fifo by now
		repeat (uartPkg::overSample * uartPkg::baudDivisor * 10) @(negedge clk);
		checkStatus("status after glitch", statusOf(0, 0, 0, 1, 0, 1));
	endtask

	initial
	begin
		errorCount = 0;
		timeoutCount = 0;
		lfsr = 32'hd86f_1d06;
		reset = 1'b1;
		cmd = uartPkg::cmdNone;
		cmdStrobe = 1'b0;
		wrData = 8'h00;
		loopback = 1'b0;
		modelRx = 1'b1;	// idle line
		repeat (2) @(negedge clk);
		reset = 1'b0;

		resetChecks();
		txFrameChecks();
		loopbackChecks();
		burstChecks();
		overrunChecks();
		glitchChecks();

		$display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
source/uartPkg.sv
source/baudTickGen.sv
source/uartFifo.sv
source/uartTrans.sv
source/uartRecv.sv
source/uartCtrl.sv
source/uartPeripheral.sv
dv/uartTb.sv

// File: source/baudTickGen.sv
`default_nettype none

// 16x oversampling tick, one clk wide
module baudTickGen #(
	parameter int divisor = 4	// clk cycles per tick
) (
	input wire clk,
	input wire reset,
	output logic sTick
);

	typedef logic [$clog2(divisor)-1:0] divCount;

	divCount cnt;	// counts down to zero then reloads

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= divCount'(divisor - 1);
		else if (cnt == '0)
			cnt <= divCount'(divisor - 1);	// reload
		else
			cnt <= cnt - 1'b1;
	end

	assign sTick = (cnt == '0);	// one cycle in every divisor

endmodule

`default_nettype wire

// File: source/uartCtrl.sv
`default_nettype none

// command decode, fifo gating, overrun and read register
module uartCtrl (
	input wire clk,
	input wire reset,
	input wire uartPkg::uartCmd cmd,
	input wire cmdStrobe,
	input wire txFull,
	input wire txEmpty,
	input wire txBusy,
	input wire [uartPkg::dataBits-1:0] rxHead,
	input wire rxFull,
	input wire rxEmpty,
	input wire rxDone,
	output logic txPush,
	output logic txStart,
	output logic rxPush,
	output logic rxPop,
	output uartPkg::uartReadWord rdData,
	output logic rdStrobe
);

	logic wrCmd;
	logic rdCmd;
	logic statCmd;
	logic lostFrame;	// frame arrived with no room
	logic overrun;
	uartPkg::uartStatus status;

	assign wrCmd   = cmdStrobe && (cmd == uartPkg::cmdWrite);
	assign rdCmd   = cmdStrobe && (cmd == uartPkg::cmdRead);
	assign statCmd = cmdStrobe && (cmd == uartPkg::cmdStat);

	////////////////////////////////////////////////////////////////////////////
	// fifo and transmitter control
	////////////////////////////////////////////////////////////////////////////

	assign txPush    = wrCmd && !txFull;	// drop writes when full
	assign txStart   = !txEmpty && !txBusy;	// held until the transmitter takes it
	assign rxPush    = rxDone && !rxFull;
	assign lostFrame = rxDone && rxFull;
	assign rxPop     = rdCmd && !rxEmpty;	// empty read pops nothing

	assign status = '{
		reserved:  2'b00,
		rxOverrun: overrun,
		txBusy:    txBusy,
		rxFull:    rxFull,
		rxEmpty:   rxEmpty,
		txFull:    txFull,
		txEmpty:   txEmpty
	};

	// sticky overrun
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (statCmd)
			overrun <= lostFrame;	// clear on read but keep a loss in this cycle
		else if (lostFrame)
			overrun <= 1'b1;
	end

	// read result, one cycle after the command
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rdStrobe <= 1'b0;
			rdData <= '0;
		end
		else
		begin
			rdStrobe <= rdCmd || statCmd;
			if (rdCmd)
				rdData.data <= rxEmpty ? '0 : rxHead;
			else if (statCmd)
				rdData.stat <= status;
			// otherwise hold until next read
		end
	end

endmodule

`default_nettype wire

// File: source/uartFifo.sv
`default_nettype none

// first word fall through, head always visible on dout
module uartFifo (
	input wire clk,
	input wire reset,
	input wire push,
	input wire pop,
	input wire [uartPkg::dataBits-1:0] din,
	output logic [uartPkg::dataBits-1:0] dout,
	output logic full,
	output logic empty
);

	typedef logic [uartPkg::fifoAddrLen:0] fifoCount;	// one extra bit for full

	logic [uartPkg::dataBits-1:0] mem [uartPkg::fifoDepth];
	logic [uartPkg::fifoAddrLen-1:0] wrPtr;
	logic [uartPkg::fifoAddrLen-1:0] rdPtr;
	fifoCount count;
	logic doPush;
	logic doPop;

	// overflow and underflow requests just fall away here
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
			// push with pop keeps the count
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	assign dout  = mem[rdPtr];	// head, no pop needed
	assign full  = (count == fifoCount'(uartPkg::fifoDepth));
	assign empty = (count == '0);

endmodule

`default_nettype wire

// File: source/uartPeripheral.sv
`default_nettype none

// serial port as seen by the processor
module uartPeripheral (
	input wire clk,
	input wire reset,
	input wire uartPkg::uartCmd cmd,
	input wire cmdStrobe,
	input wire [uartPkg::dataBits-1:0] wrData,
	output uartPkg::uartReadWord rdData,
	output logic rdStrobe,
	input wire rx,
	output logic tx
);

	logic sTick;
	logic txPush, txStart, txTake, txBusy;
	logic txFull, txEmpty;
	logic [uartPkg::dataBits-1:0] txHead;	// byte waiting for the transmitter
	logic rxPush, rxPop, rxDone;
	logic rxFull, rxEmpty;
	logic [uartPkg::dataBits-1:0] rxByte;	// straight from the receiver
	logic [uartPkg::dataBits-1:0] rxHead;	// oldest unread byte

	baudTickGen #(.divisor(uartPkg::baudDivisor)) tickGen0 (
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	////////////////////////////////////////////////////////////////////////////
	// transmit path
	////////////////////////////////////////////////////////////////////////////

	uartFifo txFifo (
		.clk(clk), .reset(reset),
		.push(txPush), .pop(txTake), .din(wrData),
		.dout(txHead), .full(txFull), .empty(txEmpty)
	);

	uartTrans trans0 (
		.clk(clk), .reset(reset), .sTick(sTick),
		.txStart(txStart), .din(txHead),
		.tx(tx), .txTake(txTake), .txBusy(txBusy)
	);

	////////////////////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////////////////////

	uartRecv recv0 (
		.clk(clk), .reset(reset), .sTick(sTick),
		.rx(rx), .rxByte(rxByte), .rxDone(rxDone)
	);

	uartFifo rxFifo (
		.clk(clk), .reset(reset),
		.push(rxPush), .pop(rxPop), .din(rxByte),
		.dout(rxHead), .full(rxFull), .empty(rxEmpty)
	);

	// command side
	uartCtrl ctrl0 (
		.clk(clk), .reset(reset),
		.cmd(cmd), .cmdStrobe(cmdStrobe),
		.txFull(txFull), .txEmpty(txEmpty), .txBusy(txBusy),
		.rxHead(rxHead), .rxFull(rxFull), .rxEmpty(rxEmpty), .rxDone(rxDone),
		.txPush(txPush), .txStart(txStart),
		.rxPush(rxPush), .rxPop(rxPop),
		.rdData(rdData), .rdStrobe(rdStrobe)
	);

endmodule

`default_nettype wire

// File: source/uartPkg.sv
`default_nettype none

package uartPkg;

	////////////////////////////////////////////////////////////////////////////
	// frame format and bit timing
	////////////////////////////////////////////////////////////////////////////

	localparam int dataBits    = 8;		// bits per character
	localparam int overSample  = 16;	// ticks per bit
	localparam int stopTicks   = 16;	// one stop bit
	localparam int baudDivisor = 4;		// clk cycles per tick, kept small for sim

	localparam int tickLen   = $clog2(overSample);	// width of the tick counters
	localparam int bitCntLen = $clog2(dataBits);	// width of the bit counters

	// counter end points, sized to match the counters
	localparam logic [tickLen-1:0] lastTick     = tickLen'(overSample - 1);
	localparam logic [tickLen-1:0] midTick      = tickLen'(overSample / 2 - 1);
	localparam logic [tickLen-1:0] lastStopTick = tickLen'(stopTicks - 1);
	localparam logic [bitCntLen-1:0] lastBit    = bitCntLen'(dataBits - 1);

	////////////////////////////////////////////////////////////////////////////
	// buffering
	////////////////////////////////////////////////////////////////////////////

	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;		// log2 of fifoDepth

	// processor side commands
	typedef enum logic [1:0] {cmdNone, cmdWrite, cmdRead, cmdStat} uartCmd;

	// shared by both serial machines
	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} serState;

	typedef struct packed {
		logic [1:0] reserved;	// always zero
		logic rxOverrun;		// sticky, cleared by a status read
		logic txBusy;
		logic rxFull;
		logic rxEmpty;
		logic txFull;
		logic txEmpty;
	} uartStatus;

	// one read register, two views
	typedef union packed {
		logic [dataBits-1:0] data;
		uartStatus stat;
	} uartReadWord;

endpackage

`default_nettype wire

// File: source/uartRecv.sv
`default_nettype none

// 8N1 receiver, 16x oversampled, mid-bit sampling
module uartRecv (
	input wire clk,
	input wire reset,
	input wire sTick,
	input wire rx,
	output logic [uartPkg::dataBits-1:0] rxByte,
	output logic rxDone
);

	uartPkg::serState stateReg, stateNext;
	logic [uartPkg::tickLen-1:0] sReg, sNext;		// ticks within a bit
	logic [uartPkg::bitCntLen-1:0] nReg, nNext;		// bits received so far
	logic [uartPkg::dataBits-1:0] bReg, bNext;		// assembling byte
	logic rxMeta, rxSync, rxLast;	// sync chain plus one for edge detect
	logic rxFall;

	////////////////////////////////////////////////////////////////////////////
	// input sync
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;	// idle line is high
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	assign rxFall = rxLast && !rxSync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::stIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDone = 1'b0;
		case (stateReg)
			uartPkg::stIdle:
			begin
				if (rxFall)
				begin
					sNext = '0;
					stateNext = uartPkg::stStart;
				end
			end
			uartPkg::stStart:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::midTick)
					begin
						// still low at mid-bit means a real start bit
						if (!rxSync)
						begin
							sNext = '0;
							nNext = '0;
							stateNext = uartPkg::stData;
						end
						else
							stateNext = uartPkg::stIdle;	// glitch
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stData:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartPkg::dataBits-1:1]};	// LSB first
						if (nReg == uartPkg::lastBit)
							stateNext = uartPkg::stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stStop:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::lastStopTick)
					begin
						rxDone = 1'b1;	// mid stop bit
						stateNext = uartPkg::stIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::stIdle;
		endcase
	end

	assign rxByte = bReg;

endmodule

`default_nettype wire

// File: source/uartTrans.sv
`default_nettype none

// 8N1 transmitter, LSB first
module uartTrans (
	input wire clk,
	input wire reset,
	input wire sTick,
	input wire txStart,
	input wire [uartPkg::dataBits-1:0] din,
	output logic tx,
	output logic txTake,	// pops the tx fifo
	output logic txBusy
);

	uartPkg::serState stateReg, stateNext;
	logic [uartPkg::tickLen-1:0] sReg, sNext;		// ticks within a bit
	logic [uartPkg::bitCntLen-1:0] nReg, nNext;		// data bit index
	logic [uartPkg::dataBits-1:0] bReg, bNext;		// outgoing byte
	logic txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::stIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txTake = 1'b0;
		case (stateReg)
			uartPkg::stIdle:
			begin
				// start on a tick so every bit is a full 16 ticks
				if (txStart && sTick)
				begin
					txTake = 1'b1;
					bNext = din;	// capture fifo head as it is popped
					sNext = '0;
					stateNext = uartPkg::stStart;
				end
			end
			uartPkg::stStart:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)
					begin
						sNext = '0;
						nNext = '0;
						stateNext = uartPkg::stData;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stData:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit to the LSB
						if (nReg == uartPkg::lastBit)
							stateNext = uartPkg::stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stStop:
			begin
				if (sTick)
				begin
					if (sReg == uartPkg::lastStopTick)
						stateNext = uartPkg::stIdle;	// frame done
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::stIdle;
		endcase

		// line level tracks the state being entered
		case (stateNext)
			uartPkg::stStart: txNext = 1'b0;
			uartPkg::stData:  txNext = bNext[0];
			default:          txNext = 1'b1;
		endcase
	end

	assign tx = txReg;
	assign txBusy = (stateReg != uartPkg::stIdle);

endmodule

`default_nettype wire
